// ==== verilog/rv_pkg.sv ====
// rv32i decode types: widths, opcode constants, alu op and operand source enums
`default_nettype none

package rv_pkg;

    // widths fixed by the isa
    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;
    typedef logic [2:0]        funct3_t;
    typedef logic [6:0]        funct7_t;
    typedef logic [6:0]        opcode_t;

    // major opcodes handled by decode
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;

    // funct3 of the immediate shifts, which carry a shamt instead of imm[11:0]
    localparam funct3_t F3_SLLI      = 3'b001;
    localparam funct3_t F3_SRLI_SRAI = 3'b101;

    // what execute does with the operands
    typedef enum logic [2:0] {
        ALU_ADDR   = 3'b000,
        ALU_BRANCH = 3'b001,
        ALU_REG    = 3'b010,
        ALU_IMM    = 3'b011,
        ALU_LUI    = 3'b100,
        ALU_AUIPC  = 3'b101
    } alu_op_t;

    // second operand source
    typedef enum logic [1:0] {
        SRC_REG = 2'b00,
        SRC_IMM = 2'b01,
        SRC_PC  = 2'b10
    } alu_src_t;

endpackage

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
// combinational rv32i instruction decoder: fields, immediates, control, source use
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  rv_pkg::word_t     instr,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::funct3_t   funct3,
    output rv_pkg::funct7_t   funct7,
    output rv_pkg::word_t     imm,
    output rv_pkg::alu_op_t   alu_op,
    output rv_pkg::alu_src_t  alu_src,
    output logic              mem_read,
    output logic              mem_write,
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              uses_rs1,
    output logic              uses_rs2,
    output logic              illegal
);
    import rv_pkg::*;

    opcode_t opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_u;
    word_t   imm_sh;

    // raw fields, passed on whatever the format
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // immediate formats, all sign extended from bit 31
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // b-type: bit 0 implied zero, bits 11 and 12 swapped around
    assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u  = {instr[31:12], 12'b0};
    // shift amount only; srai/srli selected by funct7
    assign imm_sh = {27'b0, instr[24:20]};

    always_comb
    begin
        // defaults describe an instruction that does nothing
        imm        = '0;
        alu_op     = ALU_ADDR;
        alu_src    = SRC_REG;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        uses_rs1   = 1'b0;
        uses_rs2   = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                alu_op    = ALU_REG;
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // slli/srli/srai take the shamt, the rest the i immediate
                if (funct3 == F3_SLLI || funct3 == F3_SRLI_SRAI)
                    imm = imm_sh;
                else
                    imm = imm_i;
                alu_op    = ALU_IMM;
                alu_src   = SRC_IMM;
                reg_write = 1'b1;
                uses_rs1  = 1'b1;
            end
            OPC_LUI:
            begin
                imm       = imm_u;
                alu_op    = ALU_LUI;
                alu_src   = SRC_IMM;
                reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                imm       = imm_u;
                alu_op    = ALU_AUIPC;
                alu_src   = SRC_PC;
                reg_write = 1'b1;
            end
            OPC_LOAD:
            begin
                imm        = imm_i;
                alu_src    = SRC_IMM;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                uses_rs1   = 1'b1;
            end
            OPC_STORE:
            begin
                imm       = imm_s;
                alu_src   = SRC_IMM;
                mem_write = 1'b1;
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
            end
            OPC_BRANCH:
            begin
                // compare rs1 against rs2, target from pc plus imm
                imm      = imm_b;
                alu_op   = ALU_BRANCH;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            default:
            begin
                // jal, jalr, fence, system and anything unknown
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
// 32x32 register file, two read ports, one write port, same-cycle write bypass
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];
    logic  wr_ok;

    // writes to x0 are dropped
    assign wr_ok = wb_en && (wb_rd != '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_ok)
        begin
            regs[wb_rd] <= wb_data;
        end
    end

    // read ports, write-through when the same register lands this edge
    assign rs1_data = (rs1 == '0)               ? '0      :
                      (wr_ok && wb_rd == rs1)   ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0)               ? '0      :
                      (wr_ok && wb_rd == rs2)   ? wb_data : regs[rs2];

endmodule

`default_nettype wire

// ==== verilog/issue_reg.sv ====
// id/ex pipeline register with raw hazard detection, stall and bubble insertion
`timescale 1ns/1ps
`default_nettype none

module issue_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  rv_pkg::word_t     id_pc,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  rv_pkg::funct3_t   funct3,
    input  rv_pkg::funct7_t   funct7,
    input  rv_pkg::word_t     imm,
    input  rv_pkg::alu_op_t   alu_op,
    input  rv_pkg::alu_src_t  alu_src,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              mem_to_reg,
    input  logic              reg_write,
    input  logic              uses_rs1,
    input  logic              uses_rs2,
    input  logic              illegal,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output logic              stall,
    output logic              ex_valid,
    output rv_pkg::word_t     ex_pc,
    output rv_pkg::reg_addr_t ex_rs1,
    output rv_pkg::reg_addr_t ex_rs2,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::funct3_t   ex_funct3,
    output rv_pkg::funct7_t   ex_funct7,
    output rv_pkg::word_t     ex_imm,
    output rv_pkg::word_t     ex_rs1_data,
    output rv_pkg::word_t     ex_rs2_data,
    output rv_pkg::alu_op_t   ex_alu_op,
    output rv_pkg::alu_src_t  ex_alu_src,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_mem_to_reg,
    output logic              ex_reg_write,
    output logic              ex_illegal
);
    import rv_pkg::*;

    logic ex_writer;
    logic raw_hit;
    logic issue;

    // held instruction will write a real register
    assign ex_writer = ex_valid && ex_reg_write && (ex_rd != '0);
    // only sources the decoder marks as read count
    assign raw_hit   = (uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd);
    assign stall     = id_valid && ex_writer && raw_hit;
    assign issue     = id_valid && !stall;

    // control state, cleared on reset and on a bubble
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ex_valid      <= 1'b0;
            ex_alu_op     <= ALU_ADDR;
            ex_alu_src    <= SRC_REG;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_illegal    <= 1'b0;
        end
        else
        begin
            ex_valid      <= issue;
            ex_alu_op     <= issue ? alu_op : ALU_ADDR;
            ex_alu_src    <= issue ? alu_src : SRC_REG;
            ex_mem_read   <= issue && mem_read;
            ex_mem_write  <= issue && mem_write;
            ex_mem_to_reg <= issue && mem_to_reg;
            ex_reg_write  <= issue && reg_write;
            ex_illegal    <= issue && illegal;
        end
    end

    // payload, only meaningful while ex_valid is high
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            ex_pc       <= id_pc;
            ex_rs1      <= rs1;
            ex_rs2      <= rs2;
            ex_rd       <= rd;
            ex_funct3   <= funct3;
            ex_funct7   <= funct7;
            ex_imm      <= imm;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode_stage.sv ====
// decode stage top: instruction decoder, register file and id/ex issue register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  rv_pkg::word_t     id_instr,
    input  rv_pkg::word_t     id_pc,
    input  logic              wb_en,
    input  rv_pkg::reg_addr_t wb_rd,
    input  rv_pkg::word_t     wb_data,
    output logic              stall,
    output logic              ex_valid,
    output rv_pkg::word_t     ex_pc,
    output rv_pkg::reg_addr_t ex_rs1,
    output rv_pkg::reg_addr_t ex_rs2,
    output rv_pkg::reg_addr_t ex_rd,
    output rv_pkg::funct3_t   ex_funct3,
    output rv_pkg::funct7_t   ex_funct7,
    output rv_pkg::word_t     ex_imm,
    output rv_pkg::word_t     ex_rs1_data,
    output rv_pkg::word_t     ex_rs2_data,
    output rv_pkg::alu_op_t   ex_alu_op,
    output rv_pkg::alu_src_t  ex_alu_src,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_mem_to_reg,
    output logic              ex_reg_write,
    output logic              ex_illegal
);
    import rv_pkg::*;

    // decoder outputs
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     imm;
    alu_op_t   alu_op;
    alu_src_t  alu_src;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      reg_write;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      illegal;
    // register file read data
    word_t     rs1_data;
    word_t     rs2_data;

    instr_decoder u_instr_decoder (
        .instr      (id_instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .funct3     (funct3),
        .funct7     (funct7),
        .imm        (imm),
        .alu_op     (alu_op),
        .alu_src    (alu_src),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .uses_rs1   (uses_rs1),
        .uses_rs2   (uses_rs2),
        .illegal    (illegal)
    );

    // read addresses come straight from the instruction fields
    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    issue_reg u_issue_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .id_valid      (id_valid),
        .id_pc         (id_pc),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd            (rd),
        .funct3        (funct3),
        .funct7        (funct7),
        .imm           (imm),
        .alu_op        (alu_op),
        .alu_src       (alu_src),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_to_reg    (mem_to_reg),
        .reg_write     (reg_write),
        .uses_rs1      (uses_rs1),
        .uses_rs2      (uses_rs2),
        .illegal       (illegal),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .stall         (stall),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_rd         (ex_rd),
        .ex_funct3     (ex_funct3),
        .ex_funct7     (ex_funct7),
        .ex_imm        (ex_imm),
        .ex_rs1_data   (ex_rs1_data),
        .ex_rs2_data   (ex_rs2_data),
        .ex_alu_op     (ex_alu_op),
        .ex_alu_src    (ex_alu_src),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_reg_write  (ex_reg_write),
        .ex_illegal    (ex_illegal)
    );

endmodule

`default_nettype wire

// ==== bench/decode_stage_assert.sv ====
// concurrent assertions on stall, bubble and reset behavior, bound into decode_stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             stall,
    input logic             ex_valid,
    input rv_pkg::alu_op_t  ex_alu_op,
    input rv_pkg::alu_src_t ex_alu_src,
    input logic             ex_mem_read,
    input logic             ex_mem_write,
    input logic             ex_mem_to_reg,
    input logic             ex_reg_write,
    input logic             ex_illegal
);
    import rv_pkg::*;

    logic ctrl_active;

    // any control that would make execute do something
    assign ctrl_active = ex_mem_read || ex_mem_write || ex_mem_to_reg || ex_reg_write ||
                         ex_illegal || (ex_alu_op != ALU_ADDR) || (ex_alu_src != SRC_REG);

    stall_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !ex_valid)
        else $error("stall was not followed by a bubble");

    bubble_is_quiet: assert property (@(posedge clk) !ex_valid |-> !ctrl_active)
        else $error("bubble carries an active control");

    // the bubble holds no writer, so stall drops
    stall_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else $error("stall high two cycles in a row");

    reset_is_quiet: assert property (@(posedge clk) !rst_n |-> !ex_valid && !ctrl_active && !stall)
        else $error("control output active during reset");

endmodule

bind decode_stage decode_stage_assert u_decode_stage_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .ex_valid      (ex_valid),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src    (ex_alu_src),
    .ex_mem_read   (ex_mem_read),
    .ex_mem_write  (ex_mem_write),
    .ex_mem_to_reg (ex_mem_to_reg),
    .ex_reg_write  (ex_reg_write),
    .ex_illegal    (ex_illegal)
);

`default_nettype wire

// ==== bench/tb_decode_stage.sv ====
// testbench for decode_stage: clock, reset, stimulus, reference decode, register mirror, checker
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
    import rv_pkg::*;

    // expected decode of one instruction
    typedef struct packed {
        word_t    imm;
        alu_op_t  alu_op;
        alu_src_t alu_src;
        logic     mem_read;
        logic     mem_write;
        logic     mem_to_reg;
        logic     reg_write;
        logic     uses_rs1;
        logic     uses_rs2;
        logic     illegal;
    } ctrl_t;

    logic      clk;
    logic      rst_n;
    logic      id_valid;
    word_t     id_instr;
    word_t     id_pc;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      stall;
    logic      ex_valid;
    word_t     ex_pc;
    reg_addr_t ex_rs1;
    reg_addr_t ex_rs2;
    reg_addr_t ex_rd;
    funct3_t   ex_funct3;
    funct7_t   ex_funct7;
    word_t     ex_imm;
    word_t     ex_rs1_data;
    word_t     ex_rs2_data;
    alu_op_t   ex_alu_op;
    alu_src_t  ex_alu_src;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_mem_to_reg;
    logic      ex_reg_write;
    logic      ex_illegal;

    integer    seed = 70;
    string     test_name = "init";
    word_t     next_pc;
    // register contents as seen by the reference
    word_t     mirror [32];
    // model of the held id/ex state
    logic      m_valid = 1'b0;
    word_t     m_instr;
    word_t     m_pc;
    word_t     m_d1;
    word_t     m_d2;
    // last issued writer, zero when none
    reg_addr_t writer_rd = '0;

    decode_stage u_decode_stage (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string what, input word_t expected, input word_t actual);
        if (expected !== actual)
            fail_run($sformatf("ERROR test=%s %s expected %h actual %h",
                               test_name, what, expected, actual));
    endtask

    function automatic ctrl_t ref_decode(input word_t instr);
        ctrl_t       c;
        logic [12:0] boff;
        logic        is_op;
        logic        is_imm;
        logic        is_lui;
        logic        is_auipc;
        logic        is_load;
        logic        is_store;
        logic        is_br;
        c        = '0;
        is_op    = instr[6:0] == OPC_OP;
        is_imm   = instr[6:0] == OPC_OP_IMM;
        is_lui   = instr[6:0] == OPC_LUI;
        is_auipc = instr[6:0] == OPC_AUIPC;
        is_load  = instr[6:0] == OPC_LOAD;
        is_store = instr[6:0] == OPC_STORE;
        is_br    = instr[6:0] == OPC_BRANCH;
        // branch offset in its natural bit order
        boff = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        c.reg_write  = is_op | is_imm | is_lui | is_auipc | is_load;
        c.mem_read   = is_load;
        c.mem_to_reg = is_load;
        c.mem_write  = is_store;
        c.uses_rs1   = is_op | is_imm | is_load | is_store | is_br;
        c.uses_rs2   = is_op | is_store | is_br;
        c.illegal    = !(c.reg_write | is_store | is_br);
        if (is_op)
            c.alu_op = ALU_REG;
        else if (is_imm)
            c.alu_op = ALU_IMM;
        else if (is_lui)
            c.alu_op = ALU_LUI;
        else if (is_auipc)
            c.alu_op = ALU_AUIPC;
        else if (is_br)
            c.alu_op = ALU_BRANCH;
        if (is_imm | is_lui | is_load | is_store)
            c.alu_src = SRC_IMM;
        else if (is_auipc)
            c.alu_src = SRC_PC;
        // slli, srli and srai are exactly the funct3 values ending in 01
        if (is_imm && instr[13:12] == 2'b01)
            c.imm = {27'b0, instr[24:20]};
        else if (is_imm | is_load)
            c.imm = {{20{instr[31]}}, instr[31:20]};
        else if (is_store)
            c.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        else if (is_br)
            c.imm = {{19{boff[12]}}, boff};
        else if (is_lui | is_auipc)
            c.imm = {instr[31:12], 12'h000};
        return c;
    endfunction

    // read as the decode stage sees it this cycle, write-back included
    function automatic word_t mirror_read(input reg_addr_t a);
        if (a == 5'd0)
            return '0;
        if (wb_en && wb_rd == a)
            return wb_data;
        return mirror[a];
    endfunction

    // per-cycle compare against the model, outputs sampled mid-cycle
    initial
    begin
        ctrl_t e;
        ctrl_t d;
        logic  exp_stall;
        for (int i = 0; i < 32; i++)
            mirror[i] = '0;
        forever
        begin
            @(negedge clk);
            if (m_valid)
                e = ref_decode(m_instr);
            else
                e = '0;
            check("ex_valid", 32'(m_valid), 32'(ex_valid));
            check("ex_mem_read", 32'(e.mem_read), 32'(ex_mem_read));
            check("ex_mem_write", 32'(e.mem_write), 32'(ex_mem_write));
            check("ex_mem_to_reg", 32'(e.mem_to_reg), 32'(ex_mem_to_reg));
            check("ex_reg_write", 32'(e.reg_write), 32'(ex_reg_write));
            check("ex_illegal", 32'(e.illegal), 32'(ex_illegal));
            check("ex_alu_op", 32'(e.alu_op), 32'(ex_alu_op));
            check("ex_alu_src", 32'(e.alu_src), 32'(ex_alu_src));
            if (m_valid)
            begin
                check("ex_pc", m_pc, ex_pc);
                check("ex_rd", 32'(m_instr[11:7]), 32'(ex_rd));
                check("ex_rs1", 32'(m_instr[19:15]), 32'(ex_rs1));
                check("ex_rs2", 32'(m_instr[24:20]), 32'(ex_rs2));
                check("ex_funct3", 32'(m_instr[14:12]), 32'(ex_funct3));
                check("ex_funct7", 32'(m_instr[31:25]), 32'(ex_funct7));
                check("ex_imm", e.imm, ex_imm);
                check("ex_rs1_data", m_d1, ex_rs1_data);
                check("ex_rs2_data", m_d2, ex_rs2_data);
            end
            // hazard against the last issued writer
            d = ref_decode(id_instr);
            exp_stall = id_valid && writer_rd != 5'd0 &&
                        ((d.uses_rs1 && id_instr[19:15] == writer_rd) ||
                         (d.uses_rs2 && id_instr[24:20] == writer_rd));
            check("stall", 32'(exp_stall), 32'(stall));
            if (!rst_n || !id_valid || exp_stall)
            begin
                m_valid   = 1'b0;
                writer_rd = '0;
            end
            else
            begin
                m_valid   = 1'b1;
                m_instr   = id_instr;
                m_pc      = id_pc;
                m_d1      = mirror_read(id_instr[19:15]);
                m_d2      = mirror_read(id_instr[24:20]);
                writer_rd = d.reg_write ? id_instr[11:7] : 5'd0;
            end
            if (rst_n && wb_en && wb_rd != 5'd0)
                mirror[wb_rd] = wb_data;
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            id_valid <= 1'b0;
            wb_en    <= 1'b0;
        end
    endtask

    task automatic write_reg(input reg_addr_t rd, input word_t data);
        @(posedge clk);
        id_valid <= 1'b0;
        wb_en    <= 1'b1;
        wb_rd    <= rd;
        wb_data  <= data;
    endtask

    // hold the instruction until decode takes it, count stall cycles
    task automatic present_wb(input word_t instr, input logic wen, input reg_addr_t wrd,
                              input word_t wdata, output int stalls);
        @(posedge clk);
        id_valid <= 1'b1;
        id_instr <= instr;
        id_pc    <= next_pc;
        wb_en    <= wen;
        wb_rd    <= wrd;
        wb_data  <= wdata;
        next_pc = next_pc + 4;
        stalls  = 0;
        @(negedge clk);
        while (stall)
        begin
            stalls = stalls + 1;
            if (stalls > 8)
                fail_run($sformatf("timeout in test %s: stall held for more than 8 cycles",
                                   test_name));
            @(negedge clk);
        end
    endtask

    task automatic present(input word_t instr, output int stalls);
        present_wb(instr, 1'b0, 5'd0, '0, stalls);
    endtask

    function automatic word_t enc_add(input reg_addr_t rd, input reg_addr_t rs1,
                                      input reg_addr_t rs2);
        return {7'b0, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    function automatic word_t random_instr(input logic legal);
        word_t   raw;
        opcode_t opc;
        int      kind;
        raw  = $random(seed);
        kind = $unsigned($random(seed)) % 7;
        case (kind)
            0:       opc = OPC_OP;
            1:       opc = OPC_OP_IMM;
            2:       opc = OPC_LUI;
            3:       opc = OPC_AUIPC;
            4:       opc = OPC_LOAD;
            5:       opc = OPC_STORE;
            default: opc = OPC_BRANCH;
        endcase
        if (!legal)
        begin
            // step off the decoded opcodes
            opc = raw[6:0];
            while (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                               OPC_LOAD, OPC_STORE, OPC_BRANCH})
                opc = opc + 7'd1;
        end
        return {raw[31:7], opc};
    endfunction

    initial
    begin
        int    stalls;
        word_t raw;
        rst_n    = 1'b0;
        id_valid = 1'b0;
        id_instr = '0;
        id_pc    = '0;
        wb_en    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        next_pc  = 32'h0000_1000;

        test_name = "reset";
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        idle(3);

        test_name = "regfile";
        for (int i = 1; i < 32; i++)
            write_reg(reg_addr_t'(i), $random(seed));
        // x0 must drop this
        write_reg(5'd0, 32'hdead_beef);
        idle(1);
        for (int i = 0; i < 32; i++)
            present(enc_add(5'd0, reg_addr_t'(i), reg_addr_t'(31 - i)), stalls);
        // same-cycle write seen by the reader
        present_wb(enc_add(5'd0, 5'd7, 5'd9), 1'b1, 5'd7, 32'h1234_5678, stalls);
        present_wb(enc_add(5'd0, 5'd9, 5'd9), 1'b1, 5'd9, 32'h0bad_f00d, stalls);
        idle(2);

        test_name = "dependent pair";
        present(enc_add(5'd3, 5'd1, 5'd2), stalls);
        present(enc_add(5'd4, 5'd3, 5'd1), stalls);
        check("stall cycles", 32'd1, stalls);
        idle(1);
        test_name = "load then store";
        present({12'h010, 5'd1, 3'b010, 5'd10, OPC_LOAD}, stalls);
        present({7'h00, 5'd10, 5'd2, 3'b010, 5'h04, OPC_STORE}, stalls);
        check("stall cycles", 32'd1, stalls);
        idle(1);
        test_name = "independent pair";
        present(enc_add(5'd5, 5'd1, 5'd2), stalls);
        present(enc_add(5'd6, 5'd1, 5'd2), stalls);
        check("stall cycles", 32'd0, stalls);
        idle(1);
        test_name = "x0 writer";
        present(enc_add(5'd0, 5'd1, 5'd2), stalls);
        present(enc_add(5'd6, 5'd0, 5'd0), stalls);
        check("stall cycles", 32'd0, stalls);
        idle(1);
        test_name = "lui reader";
        present(enc_add(5'd8, 5'd1, 5'd2), stalls);
        // rs1 field equals the writer but lui reads nothing
        present({12'habc, 5'd8, 3'b000, 5'd9, OPC_LUI}, stalls);
        check("stall cycles", 32'd0, stalls);
        idle(2);

        test_name = "random";
        for (int n = 0; n < 300; n++)
        begin
            raw = $random(seed);
            present_wb(random_instr(1'b1), raw[0], raw[5:1], $random(seed), stalls);
        end
        idle(2);

        test_name = "illegal";
        present({20'h00100, 5'd1, 7'b1101111}, stalls);
        present({12'h008, 5'd2, 3'b000, 5'd1, 7'b1100111}, stalls);
        for (int n = 0; n < 40; n++)
            present(random_instr(1'b0), stalls);
        idle(3);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/rv_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/issue_reg.sv
verilog/decode_stage.sv
bench/decode_stage_assert.sv
bench/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the decode stage testbench with verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_decode_stage \
        -f sources.f -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage \
    || exit 1
